// ==== verilog/req_buf_params.svh ====
`ifndef REQ_BUF_PARAMS_SVH
`define REQ_BUF_PARAMS_SVH

// Number of FIFO lanes behind the router
// Not a power of two, so the top destination code has no lane
`define REQ_BUF_NUM_LANES 3

// Destination field width in the request
// Must cover every lane index
`define REQ_BUF_DEST_W 2

// Storage slots per lane
// One slot stays unused to tell full from empty, so 3 usable entries
`define REQ_BUF_DEPTH 4

// Payload width of one request
`define REQ_BUF_DATA_W 16

// Opcode field width
// Fixed by the opcode enum in the package
`define REQ_BUF_OP_W 2

`endif

// ==== verilog/req_buf_pkg.sv ====
`include "req_buf_params.svh"

package req_buf_pkg;

    // Request opcode
    // Carried from input to output untouched, never decoded in the buffer
    typedef enum logic [`REQ_BUF_OP_W-1:0] {
        OP_READ  = 2'd0,
        OP_WRITE = 2'd1,
        OP_FLUSH = 2'd2
    } req_op_e;

    // One memory request as it travels through the buffer
    // Field order sets the bit layout: dest on top, payload in the low bits
    typedef struct packed {
        // Target lane, may point past the last lane
        logic [`REQ_BUF_DEST_W-1:0] dest;
        // Opcode, payload only
        req_op_e                    op;
        // Request data
        logic [`REQ_BUF_DATA_W-1:0] data;
    } req_t;

    // One bit per lane
    // Used for full, empty, push and pop vectors
    typedef logic [`REQ_BUF_NUM_LANES-1:0] lane_vec_t;

    // Index of a single lane
    // Sized for the lane count, not for the dest field
    typedef logic [$clog2(`REQ_BUF_NUM_LANES)-1:0] lane_idx_t;

endpackage : req_buf_pkg

// ==== verilog/fifo.sv ====
module fifo #(
    parameter int DATA_W = 16,
    parameter int DEPTH  = 4
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               push,
    input  req_buf_pkg::req_t  push_data,
    input  logic               pop,
    output req_buf_pkg::req_t  pop_data,
    output logic               full,
    output logic               empty
);

    import req_buf_pkg::*;

    // Whole entry width and the part above the payload
    localparam int ENTRY_W = $bits(req_t);
    localparam int CTRL_W  = ENTRY_W - DATA_W;
    // DEPTH of at least 2 assumed
    localparam int PTR_W   = $clog2(DEPTH);

    // Storage split into a small control array and the payload array
    logic [CTRL_W-1:0] ctrl_mem [DEPTH];
    logic [DATA_W-1:0] data_mem [DEPTH];

    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] wr_ptr_inc;
    logic [PTR_W-1:0] rd_ptr_inc;

    // Pointer step with wrap at DEPTH
    // Works for depths that are not powers of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        logic [PTR_W-1:0] nxt;
        nxt = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
        return nxt;
    endfunction

    assign wr_ptr_inc = ptr_inc(wr_ptr);
    assign rd_ptr_inc = ptr_inc(rd_ptr);

    // Equal pointers mean nothing stored
    assign empty = (wr_ptr == rd_ptr);
    // One more write would catch up with the read side, DEPTH-1 stored
    assign full  = (wr_ptr_inc == rd_ptr);

    // Head entry, visible without a pop
    assign pop_data = {ctrl_mem[rd_ptr], data_mem[rd_ptr]};

    // Entry write on push
    always_ff @(posedge clk) begin
        if (push) begin
            ctrl_mem[wr_ptr] <= push_data[ENTRY_W-1:DATA_W];
            data_mem[wr_ptr] <= push_data[DATA_W-1:0];
        end
    end

    // Pointer update
    // Push and pop in one cycle move both pointers
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr_inc;
            end
            if (pop) begin
                rd_ptr <= rd_ptr_inc;
            end
        end
    end

    // Writer must check full first
    a_no_push_full: assert property (
        @(posedge clk) disable iff (!rst_n) full |-> !push
    ) else $error("fifo: push while full");

    // Reader must check empty first
    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (!rst_n) empty |-> !pop
    ) else $error("fifo: pop while empty");

endmodule : fifo

// ==== verilog/req_router.sv ====
`include "req_buf_params.svh"

module req_router (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   in_valid,
    input  req_buf_pkg::req_t      in_req,
    input  req_buf_pkg::lane_vec_t lane_full,
    output req_buf_pkg::lane_vec_t push,
    output req_buf_pkg::req_t      push_data,
    output logic                   rej
);

    import req_buf_pkg::*;

    // Destination points at an existing lane
    logic dest_in_range;
    // Strobe landed in some lane this cycle
    logic accepted;

    assign dest_in_range = (in_req.dest < `REQ_BUF_NUM_LANES);

    // One-hot decode of dest
    // A full target lane or an unknown dest leaves push at zero
    always_comb begin
        push = '0;
        for (int i = 0; i < `REQ_BUF_NUM_LANES; i++) begin
            if (in_valid && dest_in_range && (in_req.dest == `REQ_BUF_DEST_W'(i))) begin
                push[i] = !lane_full[i];
            end
        end
    end

    assign accepted = |push;

    // Same request word goes to every lane and push picks the taker
    assign push_data = in_req;

    // Reject flag one cycle after the dropped strobe
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rej <= 1'b0;
        end else begin
            rej <= in_valid && !accepted;
        end
    end

    // A lane reporting full never receives a push
    a_no_push_to_full: assert property (
        @(posedge clk) disable iff (!rst_n) (push & lane_full) == '0
    ) else $error("req_router: push to full lane");

endmodule : req_router

// ==== verilog/rr_drain.sv ====
`include "req_buf_params.svh"

module rr_drain (
    input  logic                   clk,
    input  logic                   rst_n,
    input  req_buf_pkg::lane_vec_t lane_empty,
    input  req_buf_pkg::req_t      lane_head [`REQ_BUF_NUM_LANES],
    input  logic                   out_stall,
    output req_buf_pkg::lane_vec_t pop,
    output logic                   out_valid,
    output req_buf_pkg::req_t      out_req
);

    import req_buf_pkg::*;

    // Lane served most recently
    lane_idx_t last_q;
    // Lane chosen this cycle
    lane_idx_t grant_idx;
    logic      grant_vld;

    // Lane that sits step positions after base, wrapping at the lane count
    function automatic lane_idx_t lane_after(input lane_idx_t base, input int step);
        int sum;
        sum = int'(base) + step;
        return lane_idx_t'(sum % `REQ_BUF_NUM_LANES);
    endfunction

    // Round-robin search
    // Starts one past the last grant, so last_q itself is tried last
    always_comb begin
        grant_vld = 1'b0;
        grant_idx = last_q;
        for (int k = 1; k <= `REQ_BUF_NUM_LANES; k++) begin
            if (!grant_vld && !out_stall && !lane_empty[lane_after(last_q, k)]) begin
                grant_vld = 1'b1;
                grant_idx = lane_after(last_q, k);
            end
        end
    end

    // Pop only the granted lane
    always_comb begin
        pop = '0;
        if (grant_vld) begin
            pop[grant_idx] = 1'b1;
        end
    end

    // Pointer moves only on a grant
    // Reset value is the top lane so lane 0 goes first
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            last_q <= lane_idx_t'(`REQ_BUF_NUM_LANES - 1);
        end else if (grant_vld) begin
            last_q <= grant_idx;
        end
    end

    // Output strobe
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= grant_vld;
        end
    end

    // Head of the popped lane, captured on the popping edge
    always_ff @(posedge clk) begin
        if (grant_vld) begin
            out_req <= lane_head[grant_idx];
        end
    end

    // At most one lane drained per cycle
    a_pop_onehot0: assert property (
        @(posedge clk) disable iff (!rst_n) $onehot0(pop)
    ) else $error("rr_drain: more than one pop");

    // Stall blocks the pop and so the strobe one cycle later
    a_stall_no_pop: assert property (
        @(posedge clk) disable iff (!rst_n) out_stall |-> (pop == '0) ##1 !out_valid
    ) else $error("rr_drain: activity under stall");

endmodule : rr_drain

// ==== verilog/req_buf_top.sv ====
`include "req_buf_params.svh"

module req_buf_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   in_valid,
    input  req_buf_pkg::req_t      in_req,
    output req_buf_pkg::lane_vec_t lane_full,
    output logic                   rej,
    input  logic                   out_stall,
    output logic                   out_valid,
    output req_buf_pkg::req_t      out_req
);

    import req_buf_pkg::*;

    // Router to lanes
    lane_vec_t push_vec;
    req_t      push_data;

    // Lanes to drain
    lane_vec_t empty_vec;
    req_t      lane_head [`REQ_BUF_NUM_LANES];

    // Drain to lanes
    lane_vec_t pop_vec;

    // Steers each strobe into one lane or drops it
    // Sees the same full bits that leave on lane_full
    req_router i_req_router (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_req    (in_req),
        .lane_full (lane_full),
        .push      (push_vec),
        .push_data (push_data),
        .rej       (rej)
    );

    // One FIFO per lane, all fed the same push_data
    for (genvar i = 0; i < `REQ_BUF_NUM_LANES; i++) begin : g_lane
        fifo #(
            .DATA_W (`REQ_BUF_DATA_W),
            .DEPTH  (`REQ_BUF_DEPTH)
        ) i_fifo (
            .clk       (clk),
            .rst_n     (rst_n),
            .push      (push_vec[i]),
            .push_data (push_data),
            .pop       (pop_vec[i]),
            .pop_data  (lane_head[i]),
            .full      (lane_full[i]),
            .empty     (empty_vec[i])
        );
    end

    // Round-robin merge of the lanes onto the output port
    rr_drain i_rr_drain (
        .clk        (clk),
        .rst_n      (rst_n),
        .lane_empty (empty_vec),
        .lane_head  (lane_head),
        .out_stall  (out_stall),
        .pop        (pop_vec),
        .out_valid  (out_valid),
        .out_req    (out_req)
    );

endmodule : req_buf_top

// ==== test/req_buf_tb.sv ====
`include "req_buf_params.svh"

module req_buf_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import req_buf_pkg::*;

    localparam int NUM_LANES   = `REQ_BUF_NUM_LANES;
    localparam int FULL_LVL    = `REQ_BUF_DEPTH - 1;
    localparam int TIMEOUT     = 100;
    localparam int RAND_CYCLES = 400;

    // DUT ports
    logic      clk = 1'b0;
    logic      rst_n;
    logic      in_valid;
    req_t      in_req;
    lane_vec_t lane_full;
    logic      rej;
    logic      out_stall;
    logic      out_valid;
    req_t      out_req;

    // Acceptance guess for the current strobe, set on falling edges
    logic acc_pred;

    // Reference model, updated on rising edges only
    req_t      ref_q [NUM_LANES][$];
    int        last_lane;
    logic      chk_en = 1'b0;
    logic      seen_strobe;
    logic      stall_q;
    logic      exp_valid;
    req_t      exp_req;
    logic      exp_rej;
    lane_vec_t exp_full;
    // Two-stage tracker for a strobe into an idle buffer
    logic      lat_a;
    logic      lat_b;
    req_t      lat_req_a;
    req_t      lat_req_b;

    req_buf_top i_req_buf_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_req    (in_req),
        .lane_full (lane_full),
        .rej       (rej),
        .out_stall (out_stall),
        .out_valid (out_valid),
        .out_req   (out_req)
    );

    // 4 ns period
    always #2 clk = ~clk;

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    // Model of the buffer
    // Drain choice uses the contents before this edge, then the new push lands
    always @(posedge clk) begin
        int   grant;
        int   l;
        logic all_empty;
        req_t head;
        grant = -1;
        all_empty = 1'b1;
        if (!rst_n) begin
            for (int i = 0; i < NUM_LANES; i++) begin
                ref_q[i].delete();
            end
            // Highest lane so lane 0 is served first
            last_lane = NUM_LANES - 1;
            chk_en <= 1'b0;
            seen_strobe <= 1'b0;
            stall_q <= 1'b0;
            exp_valid <= 1'b0;
            exp_rej <= 1'b0;
            exp_full <= '0;
            lat_a <= 1'b0;
            lat_b <= 1'b0;
        end else begin
            for (int i = 0; i < NUM_LANES; i++) begin
                if (ref_q[i].size() != 0) begin
                    all_empty = 1'b0;
                end
            end
            // Round robin from the lane after the last one served
            if (!out_stall) begin
                for (int k = 1; k <= NUM_LANES; k++) begin
                    l = (last_lane + k) % NUM_LANES;
                    if (grant < 0 && ref_q[l].size() != 0) begin
                        grant = l;
                    end
                end
            end
            exp_valid <= (grant >= 0);
            if (grant >= 0) begin
                head = ref_q[grant].pop_front();
                exp_req <= head;
                last_lane = grant;
            end
            if (in_valid && acc_pred) begin
                ref_q[in_req.dest].push_back(in_req);
            end
            exp_rej <= in_valid && !acc_pred;
            for (int i = 0; i < NUM_LANES; i++) begin
                exp_full[i] <= (ref_q[i].size() == FULL_LVL);
            end
            lat_a <= in_valid && acc_pred && all_empty;
            lat_req_a <= in_req;
            lat_b <= lat_a && !out_stall;
            lat_req_b <= lat_req_a;
            chk_en <= 1'b1;
            seen_strobe <= seen_strobe || in_valid;
            stall_q <= out_stall;
        end
    end

    // Checks run on falling edges, where DUT outputs and model are both settled

    // Quiet outputs between reset and the first strobe
    a_idle_start: assert property (
        @(negedge clk) disable iff (!chk_en)
        !seen_strobe |-> (!out_valid && !rej && lane_full == '0)
    ) else fail_now($sformatf("ERROR out_valid %0h rej %0h lane_full %0h before first strobe",
                              out_valid, rej, lane_full));

    // Idle buffer gives the output two cycles after the strobe
    a_single_latency: assert property (
        @(negedge clk) disable iff (!chk_en)
        lat_b |-> (out_valid && out_req == lat_req_b)
    ) else fail_now($sformatf("ERROR out_valid %0h out_req %0h exp %0h after idle strobe",
                              out_valid, out_req, lat_req_b));

    a_out_valid: assert property (
        @(negedge clk) disable iff (!chk_en)
        out_valid == exp_valid
    ) else fail_now($sformatf("ERROR out_valid got %0h exp %0h", out_valid, exp_valid));

    // Lane order and round-robin order both show up here
    a_out_req: assert property (
        @(negedge clk) disable iff (!chk_en)
        exp_valid |-> (out_req == exp_req)
    ) else fail_now($sformatf("ERROR out_req got %0h exp %0h", out_req, exp_req));

    a_rej: assert property (
        @(negedge clk) disable iff (!chk_en)
        rej == exp_rej
    ) else fail_now($sformatf("ERROR rej got %0h exp %0h", rej, exp_rej));

    a_lane_full: assert property (
        @(negedge clk) disable iff (!chk_en)
        lane_full == exp_full
    ) else fail_now($sformatf("ERROR lane_full got %0h exp %0h", lane_full, exp_full));

    // No output in the cycle after a stalled one
    a_stall_quiet: assert property (
        @(negedge clk) disable iff (!chk_en)
        stall_q |-> !out_valid
    ) else fail_now($sformatf("ERROR out_valid got %0h exp 0 under out_stall", out_valid));

    // One strobe on the next falling edge
    task automatic drive_req(input logic [1:0] dest, input logic [1:0] op,
                             input logic [15:0] data);
        req_t r;
        @(negedge clk);
        r.dest = dest;
        r.op = req_op_e'(op);
        r.data = data;
        in_valid = 1'b1;
        in_req = r;
        // Accepted only for an existing lane that is not full right now
        if (dest < NUM_LANES) begin
            acc_pred = !lane_full[dest];
        end else begin
            acc_pred = 1'b0;
        end
    endtask

    task automatic drive_idle();
        @(negedge clk);
        in_valid = 1'b0;
        acc_pred = 1'b0;
    endtask

    function automatic logic model_idle();
        logic idle;
        idle = !exp_valid && !out_valid;
        for (int i = 0; i < NUM_LANES; i++) begin
            if (ref_q[i].size() != 0) begin
                idle = 1'b0;
            end
        end
        return idle;
    endfunction

    task automatic wait_out_valid();
        int n;
        n = 0;
        while (!out_valid && n < TIMEOUT) begin
            drive_idle();
            n++;
        end
        if (!out_valid) begin
            fail_now("Timeout while waiting for out_valid");
        end
    endtask

    task automatic wait_drained();
        int n;
        n = 0;
        while (!model_idle() && n < TIMEOUT) begin
            drive_idle();
            n++;
        end
        if (!model_idle()) begin
            fail_now("Timeout while waiting for the lanes to drain");
        end
    endtask

    initial begin
        logic [31:0] rnd;
        void'($urandom(47146));
        rst_n = 1'b0;
        in_valid = 1'b0;
        in_req = '0;
        out_stall = 1'b0;
        acc_pred = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Quiet cycles after reset
        repeat (4) drive_idle();

        // Single request into the idle buffer
        drive_req(2'd0, 2'd1, 16'h1234);
        wait_out_valid();
        wait_drained();

        // Dest with no lane behind it
        drive_req(2'd3, 2'd0, 16'hdead);
        drive_idle();
        wait_drained();

        // Fill all lanes while the output is held
        out_stall = 1'b1;
        for (int n = 0; n < FULL_LVL; n++) begin
            for (int i = 0; i < NUM_LANES; i++) begin
                drive_req(2'(i), 2'(n), 16'(16 * i + n + 16'h0a00));
            end
        end
        // Full lane and bad dest, both dropped
        drive_req(2'd1, 2'd0, 16'hbad1);
        drive_req(2'd3, 2'd2, 16'hbad3);
        repeat (3) drive_idle();
        out_stall = 1'b0;
        wait_drained();

        // Random traffic with random stall
        for (int n = 0; n < RAND_CYCLES; n++) begin
            rnd = $urandom;
            if (rnd[2:0] < 3'd5) begin
                drive_req(rnd[4:3], 2'($urandom_range(2, 0)), rnd[31:16]);
            end else begin
                drive_idle();
            end
            // Stall about a quarter of the cycles
            out_stall = (rnd[7:6] == 2'd0);
        end
        drive_idle();
        out_stall = 1'b0;
        wait_drained();

        $display("TB PASSED");
        $finish;
    end

endmodule : req_buf_tb

// ==== src.f ====
+incdir+verilog
verilog/req_buf_pkg.sv
verilog/fifo.sv
verilog/req_router.sv
verilog/rr_drain.sv
verilog/req_buf_top.sv
test/req_buf_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the request buffer testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module req_buf_tb \
    -f src.f \
    -o req_buf_sim

# A failing run exits non-zero, so keep going and judge by the log
./obj_dir/req_buf_sim > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "TB FAILED" "$LOG"; then
    echo "Simulation failed"
    exit 1
fi

if ! grep -q "TB PASSED" "$LOG"; then
    echo "Simulation ended without a result"
    exit 1
fi

echo "Simulation passed"
